/* logic/btb_pkg.sv */
// ------------------------------
// BTB shared widths and types
// Entry count, tag width and vector types
// ------------------------------
package btb_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int PC_WIDTH       = 32;
  localparam int BTB_ADDR_WIDTH = 16;
  localparam int ENTRY_NUM      = 16;

  // ------------------------------
  // Types
  // ------------------------------
  // Full fetch or decode PC
  typedef logic [PC_WIDTH-1:0] pc_t;

  // Low PC bits, used as tag and as stored target
  typedef logic [BTB_ADDR_WIDTH-1:0] btb_addr_t;

  // One bit per entry
  typedef logic [ENTRY_NUM-1:0] entry_vec_t;

  // All entry targets, slot i belongs to entry i
  typedef btb_addr_t [ENTRY_NUM-1:0] tgt_array_t;

endpackage

/* logic/btb_entry.sv */
// ------------------------------
// BTB entry
// Valid bit, tag and target with read and write tag compare
// ------------------------------
`timescale 1ns/1ps

module btb_entry (
  input  logic              btb_clk,
  input  logic              cpurst_b,
  input  logic              entry_clr,
  input  logic              entry_upd,
  input  btb_pkg::btb_addr_t rd_tag,
  input  btb_pkg::btb_addr_t upd_tag,
  input  btb_pkg::btb_addr_t upd_tgt,
  output logic              rd_hit,
  output logic              wr_hit,
  output btb_pkg::btb_addr_t entry_tgt
);

  logic               entry_vld;
  btb_pkg::btb_addr_t entry_tag;
  btb_pkg::btb_addr_t entry_tgt_q;

  // ------------------------------
  // Valid bit
  // ------------------------------
  // Clear has priority over update
  always_ff @(posedge btb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_vld <= 1'b0;
    end
    else if (entry_clr)
    begin
      entry_vld <= 1'b0;
    end
    else if (entry_upd)
    begin
      entry_vld <= 1'b1;
    end
  end

  // ------------------------------
  // Tag and target storage
  // ------------------------------
  // Payload only, qualified by the valid bit
  always_ff @(posedge btb_clk)
  begin
    if (entry_upd && !entry_clr)
    begin
      entry_tag   <= upd_tag;
      entry_tgt_q <= upd_tgt;
    end
  end

  // ------------------------------
  // Tag compare
  // ------------------------------
  // Read side looks at the fetch PC
  assign rd_hit = entry_vld && (entry_tag == rd_tag);

  // Write side looks at the decode PC
  assign wr_hit = entry_vld && (entry_tag == upd_tag);

  assign entry_tgt = entry_tgt_q;

endmodule

/* logic/btb_write_ctrl.sv */
// ------------------------------
// BTB write control
// Clear, install and replace decode plus replacement pointer
// ------------------------------
`timescale 1ns/1ps

module btb_write_ctrl (
  input  logic                btb_clk,
  input  logic                cpurst_b,
  input  logic                cp0_ifu_btb_en,
  input  logic                cp0_ifu_btb_clr,
  input  logic                id_pred_btb_upd_vld,
  input  logic                id_pred_btb_mis_pred,
  input  btb_pkg::pc_t        id_pred_btb_cur_pc,
  input  btb_pkg::pc_t        id_pred_btb_tar_pc,
  input  btb_pkg::entry_vec_t wr_hit,
  output btb_pkg::entry_vec_t entry_clr,
  output btb_pkg::entry_vec_t entry_upd,
  output btb_pkg::btb_addr_t  upd_tag,
  output btb_pkg::btb_addr_t  upd_tgt
);

  logic                wr_hit_vld;
  logic                clr_one;
  logic                upd_en;
  logic                replace;
  btb_pkg::entry_vec_t repl_ptr;

  assign wr_hit_vld = |wr_hit;

  // ------------------------------
  // Clear decode
  // ------------------------------
  // Mispredict frees only the entry holding the decode tag
  assign clr_one   = id_pred_btb_mis_pred && cp0_ifu_btb_en && wr_hit_vld;
  assign entry_clr = ({btb_pkg::ENTRY_NUM{clr_one}} & wr_hit)
                   | {btb_pkg::ENTRY_NUM{cp0_ifu_btb_clr}};

  // ------------------------------
  // Update decode
  // ------------------------------
  assign upd_en  = id_pred_btb_upd_vld && cp0_ifu_btb_en;
  assign replace = upd_en && wr_hit_vld;

  // Existing tag is overwritten in place, new tag goes under the pointer
  assign entry_upd = replace ? wr_hit
                             : ({btb_pkg::ENTRY_NUM{upd_en}} & repl_ptr);

  assign upd_tag = id_pred_btb_cur_pc[btb_pkg::BTB_ADDR_WIDTH-1:0];
  assign upd_tgt = id_pred_btb_tar_pc[btb_pkg::BTB_ADDR_WIDTH-1:0];

  // ------------------------------
  // Replacement pointer
  // ------------------------------
  // One-hot, rotates toward the higher index on each new install
  always_ff @(posedge btb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      repl_ptr <= btb_pkg::entry_vec_t'(1);
    end
    else if (upd_en && !wr_hit_vld)
    begin
      repl_ptr <= {repl_ptr[btb_pkg::ENTRY_NUM-2:0], repl_ptr[btb_pkg::ENTRY_NUM-1]};
    end
    else if (clr_one)
    begin
      // Reuse the slot just freed
      repl_ptr <= wr_hit;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_ptr_onehot: assert property (
    @(posedge btb_clk) disable iff (!cpurst_b) $onehot(repl_ptr))
    else $error("btb_write_ctrl: replacement pointer not one-hot");

  // Entries never hold the same tag twice
  a_wr_hit_onehot0: assert property (
    @(posedge btb_clk) disable iff (!cpurst_b) $onehot0(wr_hit))
    else $error("btb_write_ctrl: multiple entries hit on update tag");

endmodule

/* logic/btb_read_ctrl.sv */
// ------------------------------
// BTB read control
// Registers fetch hit and forms the predicted target
// ------------------------------
`timescale 1ns/1ps

module btb_read_ctrl (
  input  logic                btb_clk,
  input  logic                cpurst_b,
  input  logic                cp0_ifu_btb_en,
  input  logic                ctrl_btb_inst_fetch,
  input  logic                ifetch_pcgen_grant,
  input  logic                iu_ifu_tar_pc_vld,
  input  logic                id_pred_btb_upd_vld,
  input  logic                id_pred_btb_mis_pred,
  input  btb_pkg::pc_t        pcgen_btb_addr,
  input  btb_pkg::entry_vec_t rd_hit,
  input  btb_pkg::tgt_array_t tgt_array,
  output logic                btb_xx_chgflw_vld,
  output btb_pkg::pc_t        btb_pcgen_tar_pc
);

  logic                rd_hit_vld;
  logic                fetch_qual;
  logic                pred_flop;
  btb_pkg::entry_vec_t hit_flop;
  btb_pkg::btb_addr_t  hit_tgt;

  // ------------------------------
  // Fetch qualification
  // ------------------------------
  // Decode traffic in the same cycle blocks the prediction
  assign rd_hit_vld = |rd_hit;
  assign fetch_qual = ctrl_btb_inst_fetch && rd_hit_vld
                   && !id_pred_btb_upd_vld && !id_pred_btb_mis_pred
                   && ifetch_pcgen_grant;

  always_ff @(posedge btb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      hit_flop <= '0;
    end
    else if (fetch_qual)
    begin
      hit_flop <= rd_hit;
    end
  end

  // Single-cycle pulse, suppressed by a redirect from execute
  always_ff @(posedge btb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      pred_flop <= 1'b0;
    end
    else
    begin
      pred_flop <= fetch_qual && cp0_ifu_btb_en && !iu_ifu_tar_pc_vld;
    end
  end

  // ------------------------------
  // Target select
  // ------------------------------
  // AND-OR mux over the one-hot registered hit
  always_comb
  begin
    hit_tgt = '0;
    for (int i = 0; i < btb_pkg::ENTRY_NUM; i++)
    begin
      hit_tgt = hit_tgt | ({btb_pkg::BTB_ADDR_WIDTH{hit_flop[i]}} & tgt_array[i]);
    end
  end

  assign btb_xx_chgflw_vld = pred_flop;
  assign btb_pcgen_tar_pc  = {pcgen_btb_addr[btb_pkg::PC_WIDTH-1:btb_pkg::BTB_ADDR_WIDTH],
                              hit_tgt};

  // Pulse must always point at exactly one entry
  a_pred_hit_onehot: assert property (
    @(posedge btb_clk) disable iff (!cpurst_b)
      btb_xx_chgflw_vld |-> $onehot(hit_flop))
    else $error("btb_read_ctrl: prediction without single registered hit");

endmodule

/* logic/btb_top.sv */
// ------------------------------
// Branch target buffer top
// Entry array with write and read control
// ------------------------------
`timescale 1ns/1ps

module btb_top (
  input  logic         btb_clk,
  input  logic         cpurst_b,
  input  logic         cp0_ifu_btb_en,
  input  logic         cp0_ifu_btb_clr,
  input  logic         ctrl_btb_inst_fetch,
  input  logic         ifetch_pcgen_grant,
  input  btb_pkg::pc_t pcgen_btb_pc,
  input  btb_pkg::pc_t pcgen_btb_addr,
  input  logic         id_pred_btb_upd_vld,
  input  logic         id_pred_btb_mis_pred,
  input  btb_pkg::pc_t id_pred_btb_cur_pc,
  input  btb_pkg::pc_t id_pred_btb_tar_pc,
  input  logic         iu_ifu_tar_pc_vld,
  output logic         btb_xx_chgflw_vld,
  output btb_pkg::pc_t btb_pcgen_tar_pc
);

  btb_pkg::entry_vec_t rd_hit;
  btb_pkg::entry_vec_t wr_hit;
  btb_pkg::entry_vec_t entry_clr;
  btb_pkg::entry_vec_t entry_upd;
  btb_pkg::btb_addr_t  rd_tag;
  btb_pkg::btb_addr_t  upd_tag;
  btb_pkg::btb_addr_t  upd_tgt;
  btb_pkg::tgt_array_t tgt_array;

  // Fetch tag is the low part of the fetch PC
  assign rd_tag = pcgen_btb_pc[btb_pkg::BTB_ADDR_WIDTH-1:0];

  // ------------------------------
  // Entry array
  // ------------------------------
  for (genvar i = 0; i < btb_pkg::ENTRY_NUM; i++)
  begin : g_entry
    btb_entry u_entry (
      .btb_clk   (btb_clk),
      .cpurst_b  (cpurst_b),
      .entry_clr (entry_clr[i]),
      .entry_upd (entry_upd[i]),
      .rd_tag    (rd_tag),
      .upd_tag   (upd_tag),
      .upd_tgt   (upd_tgt),
      .rd_hit    (rd_hit[i]),
      .wr_hit    (wr_hit[i]),
      .entry_tgt (tgt_array[i])
    );
  end

  // ------------------------------
  // Write port
  // ------------------------------
  btb_write_ctrl u_write_ctrl (
    .btb_clk              (btb_clk),
    .cpurst_b             (cpurst_b),
    .cp0_ifu_btb_en       (cp0_ifu_btb_en),
    .cp0_ifu_btb_clr      (cp0_ifu_btb_clr),
    .id_pred_btb_upd_vld  (id_pred_btb_upd_vld),
    .id_pred_btb_mis_pred (id_pred_btb_mis_pred),
    .id_pred_btb_cur_pc   (id_pred_btb_cur_pc),
    .id_pred_btb_tar_pc   (id_pred_btb_tar_pc),
    .wr_hit               (wr_hit),
    .entry_clr            (entry_clr),
    .entry_upd            (entry_upd),
    .upd_tag              (upd_tag),
    .upd_tgt              (upd_tgt)
  );

  // ------------------------------
  // Read port
  // ------------------------------
  btb_read_ctrl u_read_ctrl (
    .btb_clk              (btb_clk),
    .cpurst_b             (cpurst_b),
    .cp0_ifu_btb_en       (cp0_ifu_btb_en),
    .ctrl_btb_inst_fetch  (ctrl_btb_inst_fetch),
    .ifetch_pcgen_grant   (ifetch_pcgen_grant),
    .iu_ifu_tar_pc_vld    (iu_ifu_tar_pc_vld),
    .id_pred_btb_upd_vld  (id_pred_btb_upd_vld),
    .id_pred_btb_mis_pred (id_pred_btb_mis_pred),
    .pcgen_btb_addr       (pcgen_btb_addr),
    .rd_hit               (rd_hit),
    .tgt_array            (tgt_array),
    .btb_xx_chgflw_vld    (btb_xx_chgflw_vld),
    .btb_pcgen_tar_pc     (btb_pcgen_tar_pc)
  );

  // No two entries may hold the fetch tag at once
  a_rd_hit_onehot0: assert property (
    @(posedge btb_clk) disable iff (!cpurst_b) $onehot0(rd_hit))
    else $error("btb_top: multiple entries hit on fetch tag");

endmodule

/* include/btb_tb_tasks.svh */
// ------------------------------
// BTB testbench tasks
// Drivers, model upkeep and directed tests
// ------------------------------
`ifndef BTB_TB_TASKS_SVH
`define BTB_TB_TASKS_SVH

// Drive point, 1 ns after the rising edge
task automatic step();
  @(posedge btb_clk);
  #1;
endtask

task automatic apply_reset();
  cpurst_b = 1'b0;
  repeat (5) @(posedge btb_clk);
  #1;
  cpurst_b = 1'b1;
  for (int i = 0; i < N; i++)
  begin
    m_vld[i] = 1'b0;
  end
  m_ptr = 0;
  used_tags.delete();
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  assert (got === exp)
  else
  begin
    errors++;
    $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
  end
endtask

function automatic int model_find(input btb_pkg::btb_addr_t tag);
  int idx;
  idx = -1;
  for (int i = 0; i < N; i++)
  begin
    if (m_vld[i] && m_tag[i] == tag)
    begin
      idx = i;
    end
  end
  return idx;
endfunction

// Tag never handed out before
task automatic new_tag(output btb_pkg::btb_addr_t tag);
  btb_pkg::btb_addr_t cand;
  bit                 dup;
  dup = 1'b1;
  while (dup)
  begin
    cand = btb_pkg::btb_addr_t'($random(seed));
    dup  = 1'b0;
    foreach (used_tags[i])
    begin
      if (used_tags[i] == cand)
      begin
        dup = 1'b1;
      end
    end
  end
  used_tags.push_back(cand);
  tag = cand;
endtask

// ------------------------------
// Drivers
// ------------------------------
task automatic do_update(input btb_pkg::btb_addr_t tag, input btb_pkg::btb_addr_t tgt);
  int idx;
  id_pred_btb_upd_vld = 1'b1;
  id_pred_btb_cur_pc  = {btb_pkg::btb_addr_t'($random(seed)), tag};
  id_pred_btb_tar_pc  = {btb_pkg::btb_addr_t'($random(seed)), tgt};
  step();
  id_pred_btb_upd_vld = 1'b0;
  if (cp0_ifu_btb_en)
  begin
    idx = model_find(tag);
    if (idx >= 0)
    begin
      m_tgt[idx] = tgt;
    end
    else
    begin
      m_tag[m_ptr] = tag;
      m_tgt[m_ptr] = tgt;
      m_vld[m_ptr] = 1'b1;
      m_ptr        = (m_ptr + 1) % N;
    end
  end
endtask

task automatic do_mispredict(input btb_pkg::btb_addr_t tag);
  int idx;
  id_pred_btb_mis_pred = 1'b1;
  id_pred_btb_cur_pc   = {btb_pkg::btb_addr_t'($random(seed)), tag};
  step();
  id_pred_btb_mis_pred = 1'b0;
  idx = model_find(tag);
  if (cp0_ifu_btb_en && idx >= 0)
  begin
    m_vld[idx] = 1'b0;
    m_ptr      = idx;
  end
endtask

task automatic pulse_clear();
  cp0_ifu_btb_clr = 1'b1;
  step();
  cp0_ifu_btb_clr = 1'b0;
  for (int i = 0; i < N; i++)
  begin
    m_vld[i] = 1'b0;
  end
endtask

// Fetch one cycle, sample in the pulse cycle and the one after
task automatic do_fetch(input btb_pkg::btb_addr_t tag, input btb_pkg::pc_t addr,
                        input logic grant, input logic redirect, output logic pulse,
                        output btb_pkg::pc_t tgt_pc, output logic pulse_next);
  ctrl_btb_inst_fetch = 1'b1;
  ifetch_pcgen_grant  = grant;
  iu_ifu_tar_pc_vld   = redirect;
  pcgen_btb_pc        = {addr[31:16], tag};
  pcgen_btb_addr      = addr;
  step();
  ctrl_btb_inst_fetch = 1'b0;
  ifetch_pcgen_grant  = 1'b0;
  iu_ifu_tar_pc_vld   = 1'b0;
  @(negedge btb_clk);
  pulse  = btb_xx_chgflw_vld;
  tgt_pc = btb_pcgen_tar_pc;
  step();
  @(negedge btb_clk);
  pulse_next = btb_xx_chgflw_vld;
  step();
endtask

// Granted fetch, expectation taken from the model
task automatic expect_pred(input btb_pkg::btb_addr_t tag);
  btb_pkg::pc_t addr;
  btb_pkg::pc_t tgt_pc;
  logic         pulse;
  logic         pulse_next;
  int           idx;
  addr = $random(seed);
  idx  = model_find(tag);
  do_fetch(tag, addr, 1'b1, 1'b0, pulse, tgt_pc, pulse_next);
  if (idx >= 0 && cp0_ifu_btb_en)
  begin
    check_val("btb_xx_chgflw_vld", pulse, 1);
    check_val("btb_pcgen_tar_pc", tgt_pc, {addr[31:16], m_tgt[idx]});
  end
  else
  begin
    check_val("btb_xx_chgflw_vld", pulse, 0);
  end
  check_val("btb_xx_chgflw_vld after pulse", pulse_next, 0);
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic reset_no_pred();
  repeat (4)
  begin
    expect_pred(btb_pkg::btb_addr_t'($random(seed)));
  end
endtask

task automatic install_predict();
  btb_pkg::btb_addr_t tag;
  btb_pkg::pc_t       tgt_pc;
  logic               pulse;
  logic               pulse_next;
  new_tag(tag);
  do_update(tag, btb_pkg::btb_addr_t'($random(seed)));
  expect_pred(tag);
  // No grant, no prediction
  do_fetch(tag, $random(seed), 1'b0, 1'b0, pulse, tgt_pc, pulse_next);
  check_val("btb_xx_chgflw_vld without grant", pulse, 0);
  // Redirect from execute kills it too
  do_fetch(tag, $random(seed), 1'b1, 1'b1, pulse, tgt_pc, pulse_next);
  check_val("btb_xx_chgflw_vld with redirect", pulse, 0);
endtask

task automatic replace_in_place();
  btb_pkg::btb_addr_t tag;
  new_tag(tag);
  do_update(tag, btb_pkg::btb_addr_t'($random(seed)));
  do_update(tag, btb_pkg::btb_addr_t'($random(seed)));
  check_val("repl_ptr", DUT.u_write_ctrl.repl_ptr, 32'(1) << m_ptr);
  expect_pred(tag);
endtask

task automatic fill_and_evict();
  btb_pkg::btb_addr_t tags [N+1];
  apply_reset();
  for (int i = 0; i < N; i++)
  begin
    new_tag(tags[i]);
    do_update(tags[i], btb_pkg::btb_addr_t'($random(seed)));
  end
  for (int i = 0; i < N; i++)
  begin
    expect_pred(tags[i]);
  end
  new_tag(tags[N]);
  do_update(tags[N], btb_pkg::btb_addr_t'($random(seed)));
  for (int i = 0; i <= N; i++)
  begin
    expect_pred(tags[i]);
  end
endtask

// Relies on the full array left by the fill test
task automatic mispredict_frees_slot();
  btb_pkg::btb_addr_t victim;
  btb_pkg::btb_addr_t tag;
  victim = m_tag[5];
  do_mispredict(victim);
  check_val("repl_ptr after mispredict", DUT.u_write_ctrl.repl_ptr, 32'(1) << m_ptr);
  expect_pred(victim);
  new_tag(tag);
  do_update(tag, btb_pkg::btb_addr_t'($random(seed)));
  for (int i = 0; i < N; i++)
  begin
    expect_pred(m_tag[i]);
  end
  expect_pred(victim);
endtask

task automatic clear_and_enable();
  btb_pkg::btb_addr_t kept;
  btb_pkg::btb_addr_t dropped;
  pulse_clear();
  for (int i = 0; i < N; i++)
  begin
    expect_pred(m_tag[i]);
  end
  new_tag(kept);
  do_update(kept, btb_pkg::btb_addr_t'($random(seed)));
  cp0_ifu_btb_en = 1'b0;
  new_tag(dropped);
  do_update(dropped, btb_pkg::btb_addr_t'($random(seed)));
  expect_pred(kept);
  expect_pred(dropped);
  cp0_ifu_btb_en = 1'b1;
  expect_pred(kept);
  expect_pred(dropped);
endtask

`endif

/* verification/btb_tb.sv */
// ------------------------------
// BTB testbench
// Directed tests against a reference model of the entry array
// ------------------------------
`timescale 1ns/1ps

module btb_tb;

  localparam int N = btb_pkg::ENTRY_NUM;
  // All tests together take about 300 cycles
  localparam int MAX_CYCLES = 2000;

  logic         btb_clk;
  logic         cpurst_b;
  logic         cp0_ifu_btb_en;
  logic         cp0_ifu_btb_clr;
  logic         ctrl_btb_inst_fetch;
  logic         ifetch_pcgen_grant;
  btb_pkg::pc_t pcgen_btb_pc;
  btb_pkg::pc_t pcgen_btb_addr;
  logic         id_pred_btb_upd_vld;
  logic         id_pred_btb_mis_pred;
  btb_pkg::pc_t id_pred_btb_cur_pc;
  btb_pkg::pc_t id_pred_btb_tar_pc;
  logic         iu_ifu_tar_pc_vld;
  logic         btb_xx_chgflw_vld;
  btb_pkg::pc_t btb_pcgen_tar_pc;

  // ------------------------------
  // Reference model
  // ------------------------------
  btb_pkg::btb_addr_t m_tag [N];
  btb_pkg::btb_addr_t m_tgt [N];
  logic               m_vld [N];
  int                 m_ptr;

  btb_pkg::btb_addr_t used_tags [$];
  integer             seed = 32'he23d_30a5;
  int                 errors = 0;
  int                 checks = 0;
  int                 cycles = 0;

  btb_top DUT (
    .btb_clk              (btb_clk),
    .cpurst_b             (cpurst_b),
    .cp0_ifu_btb_en       (cp0_ifu_btb_en),
    .cp0_ifu_btb_clr      (cp0_ifu_btb_clr),
    .ctrl_btb_inst_fetch  (ctrl_btb_inst_fetch),
    .ifetch_pcgen_grant   (ifetch_pcgen_grant),
    .pcgen_btb_pc         (pcgen_btb_pc),
    .pcgen_btb_addr       (pcgen_btb_addr),
    .id_pred_btb_upd_vld  (id_pred_btb_upd_vld),
    .id_pred_btb_mis_pred (id_pred_btb_mis_pred),
    .id_pred_btb_cur_pc   (id_pred_btb_cur_pc),
    .id_pred_btb_tar_pc   (id_pred_btb_tar_pc),
    .iu_ifu_tar_pc_vld    (iu_ifu_tar_pc_vld),
    .btb_xx_chgflw_vld    (btb_xx_chgflw_vld),
    .btb_pcgen_tar_pc     (btb_pcgen_tar_pc)
  );

  initial
  begin
    btb_clk = 1'b0;
    forever #2 btb_clk = ~btb_clk;
  end

  // Run limit
  always @(posedge btb_clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: simulation ran past %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  `include "btb_tb_tasks.svh"

  initial
  begin
    cpurst_b             = 1'b0;
    cp0_ifu_btb_en       = 1'b1;
    cp0_ifu_btb_clr      = 1'b0;
    ctrl_btb_inst_fetch  = 1'b0;
    ifetch_pcgen_grant   = 1'b0;
    pcgen_btb_pc         = '0;
    pcgen_btb_addr       = '0;
    id_pred_btb_upd_vld  = 1'b0;
    id_pred_btb_mis_pred = 1'b0;
    id_pred_btb_cur_pc   = '0;
    id_pred_btb_tar_pc   = '0;
    iu_ifu_tar_pc_vld    = 1'b0;
    apply_reset();
    reset_no_pred();
    install_predict();
    replace_in_place();
    fill_and_evict();
    mispredict_frees_slot();
    clear_and_enable();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* btb_top.f */
+incdir+include
logic/btb_pkg.sv
logic/btb_entry.sv
logic/btb_write_ctrl.sv
logic/btb_read_ctrl.sv
logic/btb_top.sv
verification/btb_tb.sv
